//--- logic/burst_planner.sv
`timescale 1ns/10ps
`include "rd_burst_config.svh"

module burst_planner (
    input  logic                    aclk,
    input  logic                    aresetn,
    input  rd_burst_pkg::addr_t     fifo_addr,
    input  rd_burst_pkg::word_cnt_t fifo_len,
    input  logic                    fifo_empty,
    input  logic                    pop,
    output logic                    fifo_pop,
    output rd_burst_pkg::offset_t   first_offset,
    output rd_burst_pkg::offset_t   last_offset,
    plan_if.planner                 plan
);

    localparam int BEAT_SH  = $clog2(`RD_BEAT_BYTES);
    localparam int BURST_SH = $clog2(`RD_BURST_MAX);

    rd_burst_pkg::addr_t aligned_start;
    rd_burst_pkg::addr_t byte_span;
    rd_burst_pkg::addr_t end_next;
    rd_burst_pkg::addr_t end_byte;
    rd_burst_pkg::addr_t beats_m1;
    rd_burst_pkg::addr_t bursts_all;
    logic                take;

    // ====================
    // request math on the fifo head
    // ====================

    // word aligned start, low two bits dropped
    assign aligned_start = {fifo_addr[`RD_ADDR_W-1:2], 2'b00};
    assign byte_span     = fifo_len << 2;
    // first byte past the request
    assign end_next      = aligned_start + byte_span;
    assign end_byte      = end_next - 1'b1;

    // beats touched, minus one
    assign beats_m1   = (end_byte >> BEAT_SH) - (aligned_start >> BEAT_SH);
    // full bursts plus the remainder burst
    assign bursts_all = (beats_m1 >> BURST_SH) + 1'b1;

    // only a real head is taken
    assign take     = pop && !fifo_empty;
    assign fifo_pop = take;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            plan.plan_load <= 1'b0;
        end else begin
            plan.plan_load <= take;
        end
    end

    // plan fields hold until the next pop
    always_ff @(posedge aclk) begin
        if (take) begin
            plan.plan_base     <= aligned_start & ~rd_burst_pkg::addr_t'(`RD_BEAT_BYTES - 1);
            plan.plan_bursts   <= bursts_all[`RD_BURST_CNT_W-1:0];
            // remainder zero wraps to code 15
            plan.plan_last_len <= beats_m1[BURST_SH-1:0];
            first_offset       <= aligned_start[BEAT_SH-1:0];
            last_offset        <= end_next[BEAT_SH-1:0];
        end
    end

endmodule

//--- logic/burst_sequencer.sv
`timescale 1ns/10ps
`include "rd_burst_config.svh"

module burst_sequencer (
    input  logic                     aclk,
    input  logic                     aresetn,
    input  logic                     fifo_empty,
    input  logic                     burst_ok,
    output logic                     pop,
    output rd_burst_pkg::addr_t      burst_addr,
    output rd_burst_pkg::burst_len_t burst_len,
    output logic                     burst_valid,
    output logic                     first_burst,
    output logic                     last_burst,
    plan_if.sequencer                plan,
    credit_if.sequencer              credit
);

    localparam int BEAT_SH = $clog2(`RD_BEAT_BYTES);
    localparam rd_burst_pkg::burst_len_t FULL_LEN = rd_burst_pkg::burst_len_t'(`RD_BURST_MAX - 1);

    rd_burst_pkg::seq_state_e state;
    rd_burst_pkg::seq_state_e state_nxt;
    rd_burst_pkg::burst_cnt_t issue_cnt;
    rd_burst_pkg::burst_cnt_t total_r;
    rd_burst_pkg::addr_t      step;
    logic                     accept;
    logic                     is_last;

    // handshake and burst position
    assign accept  = burst_valid && burst_ok;
    assign is_last = (issue_cnt == total_r - 1'b1);

    // bytes covered by the current burst
    assign step = (rd_burst_pkg::addr_t'(burst_len) + 1'b1) << BEAT_SH;

    assign pop = (state == rd_burst_pkg::SEQ_IDLE) && !fifo_empty;

    // only the final burst is short
    assign burst_len   = is_last ? plan.plan_last_len : FULL_LEN;
    assign first_burst = burst_valid && (issue_cnt == '0);
    assign last_burst  = burst_valid && is_last;

    assign credit.issue = accept;
    assign credit.total = total_r;

    // ====================
    // state machine
    // ====================
    always_comb begin
        state_nxt = state;
        case (state)
            rd_burst_pkg::SEQ_IDLE: begin
                if (!fifo_empty) begin
                    state_nxt = rd_burst_pkg::SEQ_LOAD;
                end
            end
            rd_burst_pkg::SEQ_LOAD: begin
                if (plan.plan_load) begin
                    state_nxt = rd_burst_pkg::SEQ_ISSUE;
                end
            end
            rd_burst_pkg::SEQ_ISSUE: begin
                if (accept && is_last) begin
                    state_nxt = rd_burst_pkg::SEQ_DRAIN;
                end
            end
            rd_burst_pkg::SEQ_DRAIN: begin
                // wait for the data of every burst
                if (credit.all_returned) begin
                    state_nxt = rd_burst_pkg::SEQ_IDLE;
                end
            end
            default: begin
                state_nxt = rd_burst_pkg::SEQ_IDLE;
            end
        endcase
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state       <= rd_burst_pkg::SEQ_IDLE;
            burst_valid <= 1'b0;
            issue_cnt   <= '0;
            total_r     <= '0;
        end else begin
            state <= state_nxt;
            case (state)
                rd_burst_pkg::SEQ_LOAD: begin
                    if (plan.plan_load) begin
                        issue_cnt   <= '0;
                        total_r     <= plan.plan_bursts;
                        burst_valid <= credit.credit_avail;
                    end
                end
                rd_burst_pkg::SEQ_ISSUE: begin
                    if (accept) begin
                        issue_cnt   <= issue_cnt + 1'b1;
                        // credit_avail already counts this issue
                        burst_valid <= !is_last && credit.credit_avail;
                    end else if (!burst_valid) begin
                        burst_valid <= credit.credit_avail;
                    end
                end
                default: begin
                    burst_valid <= 1'b0;
                end
            endcase
        end
    end

    // address steps by the accepted burst size
    always_ff @(posedge aclk) begin
        if ((state == rd_burst_pkg::SEQ_LOAD) && plan.plan_load) begin
            burst_addr <= plan.plan_base;
        end else if (accept) begin
            burst_addr <= burst_addr + step;
        end
    end

endmodule

//--- logic/completion_tracker.sv
`timescale 1ns/10ps
`include "rd_burst_config.svh"

module completion_tracker (
    input  logic                  aclk,
    input  logic                  aresetn,
    input  rd_burst_pkg::outstd_t cfg_outstd,
    input  logic                  cfg_outstd_en,
    input  logic                  rdata_ok,
    output logic                  request_done,
    credit_if.tracker             credit
);

    rd_burst_pkg::outstd_t    limit;
    rd_burst_pkg::outstd_t    inflight_cnt;
    logic [`RD_OUTSTD_W:0]    inflight_nxt;
    rd_burst_pkg::burst_cnt_t returned_cnt;
    logic                     last_return;

    // ====================
    // credit window
    // ====================

    // one credit when outstanding is off
    assign limit = cfg_outstd_en ? cfg_outstd : rd_burst_pkg::outstd_t'(1);

    // bursts in flight after this cycle
    assign inflight_nxt = {1'b0, inflight_cnt} + credit.issue - rdata_ok;

    // a new burst next cycle still fits the window
    assign credit.credit_avail = (inflight_nxt < {1'b0, limit});

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            inflight_cnt <= '0;
        end else begin
            inflight_cnt <= inflight_nxt[`RD_OUTSTD_W-1:0];
        end
    end

    // ====================
    // returned bursts
    // ====================

    // this return completes the request
    assign last_return = rdata_ok && (returned_cnt + 1'b1 == credit.total);

    // total is zero before the first request
    assign credit.all_returned = (credit.total != '0) && (returned_cnt == credit.total);

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            returned_cnt <= '0;
            request_done <= 1'b0;
        end else begin
            request_done <= last_return;
            if (request_done) begin
                returned_cnt <= '0;
            end else if (rdata_ok) begin
                returned_cnt <= returned_cnt + 1'b1;
            end
        end
    end

endmodule

//--- logic/rd_burst_config.svh
`ifndef RD_BURST_CONFIG_SVH
`define RD_BURST_CONFIG_SVH

// ====================
// read burst generator sizing
// ====================

// byte address width, also used for word counts
`define RD_ADDR_W       32

// bytes carried by one beat
`define RD_BEAT_BYTES   32

// beats in a full burst
`define RD_BURST_MAX    16

// width of the outstanding setting
`define RD_OUTSTD_W     4

// bursts per request fit in this many bits
`define RD_BURST_CNT_W  23

`endif

//--- logic/rd_burst_if.sv
`timescale 1ns/10ps

// ====================
// burst plan, planner to sequencer
// ====================
interface plan_if;

    // one cycle after the fifo pop
    logic                     plan_load;
    // first burst address, beat aligned
    rd_burst_pkg::addr_t      plan_base;
    // bursts in the request
    rd_burst_pkg::burst_cnt_t plan_bursts;
    // length code of the final burst
    rd_burst_pkg::burst_len_t plan_last_len;

    modport planner (
        output plan_load,
        output plan_base,
        output plan_bursts,
        output plan_last_len
    );

    modport sequencer (
        input  plan_load,
        input  plan_base,
        input  plan_bursts,
        input  plan_last_len
    );

endinterface

// ====================
// credit window, sequencer to tracker
// ====================
interface credit_if;

    // accepted burst this cycle
    logic                     issue;
    // bursts of the running request
    rd_burst_pkg::burst_cnt_t total;
    // a burst may be started next cycle
    logic                     credit_avail;
    // every burst of the request has returned
    logic                     all_returned;

    modport sequencer (
        output issue,
        output total,
        input  credit_avail,
        input  all_returned
    );

    modport tracker (
        input  issue,
        input  total,
        output credit_avail,
        output all_returned
    );

endinterface

//--- logic/rd_burst_pkg.sv
`include "rd_burst_config.svh"

package rd_burst_pkg;

    // byte address on the read channel
    typedef logic [`RD_ADDR_W-1:0] addr_t;

    // request length in 32-bit words
    typedef logic [`RD_ADDR_W-1:0] word_cnt_t;

    // number of bursts in one request
    typedef logic [`RD_BURST_CNT_W-1:0] burst_cnt_t;

    // burst length code, beats minus one
    typedef logic [$clog2(`RD_BURST_MAX)-1:0] burst_len_t;

    // byte position inside one beat
    typedef logic [$clog2(`RD_BEAT_BYTES)-1:0] offset_t;

    // outstanding burst limit
    typedef logic [`RD_OUTSTD_W-1:0] outstd_t;

    // address sequencer states
    typedef enum logic [2:0] {
        SEQ_IDLE,
        SEQ_LOAD,
        SEQ_ISSUE,
        SEQ_DRAIN
    } seq_state_e;

endpackage

//--- logic/rd_burst_top.sv
`timescale 1ns/10ps
`include "rd_burst_config.svh"

module rd_burst_top (
    input  logic                               aclk,
    input  logic                               aresetn,
    // request fifo
    input  logic [`RD_ADDR_W-1:0]              fifo_addr,
    input  logic [`RD_ADDR_W-1:0]              fifo_len,
    input  logic                               fifo_empty,
    output logic                               fifo_pop,
    // outstanding window
    input  logic [`RD_OUTSTD_W-1:0]            cfg_outstd,
    input  logic                               cfg_outstd_en,
    // address channel
    output logic [`RD_ADDR_W-1:0]              burst_addr,
    output logic [$clog2(`RD_BURST_MAX)-1:0]   burst_len,
    output logic                               burst_valid,
    output logic                               first_burst,
    output logic                               last_burst,
    input  logic                               burst_ok,
    // one pulse per finished burst
    input  logic                               rdata_ok,
    // status
    output logic [$clog2(`RD_BEAT_BYTES)-1:0]  first_offset,
    output logic [$clog2(`RD_BEAT_BYTES)-1:0]  last_offset,
    output logic                               request_done
);

    logic pop;

    plan_if   u_plan ();
    credit_if u_credit ();

    // fifo head to burst plan
    burst_planner u_planner (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .fifo_addr    (fifo_addr),
        .fifo_len     (fifo_len),
        .fifo_empty   (fifo_empty),
        .pop          (pop),
        .fifo_pop     (fifo_pop),
        .first_offset (first_offset),
        .last_offset  (last_offset),
        .plan         (u_plan.planner)
    );

    // address bursts under the credit window
    burst_sequencer u_sequencer (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .fifo_empty  (fifo_empty),
        .burst_ok    (burst_ok),
        .pop         (pop),
        .burst_addr  (burst_addr),
        .burst_len   (burst_len),
        .burst_valid (burst_valid),
        .first_burst (first_burst),
        .last_burst  (last_burst),
        .plan        (u_plan.sequencer),
        .credit      (u_credit.sequencer)
    );

    completion_tracker u_tracker (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .cfg_outstd    (cfg_outstd),
        .cfg_outstd_en (cfg_outstd_en),
        .rdata_ok      (rdata_ok),
        .request_done  (request_done),
        .credit        (u_credit.tracker)
    );

endmodule

//--- project.f
+incdir+logic
logic/rd_burst_pkg.sv
logic/rd_burst_if.sv
logic/burst_planner.sv
logic/burst_sequencer.sv
logic/completion_tracker.sv
logic/rd_burst_top.sv
tb/rd_burst_chk.sv
tb/tb_rd_burst.sv

//--- tb/rd_burst_chk.sv
`timescale 1ns/10ps

module rd_burst_chk (
    input  logic                     aclk,
    input  logic                     aresetn,
    input  logic                     burst_valid,
    input  logic                     burst_ok,
    input  rd_burst_pkg::addr_t      burst_addr,
    input  rd_burst_pkg::burst_len_t burst_len,
    input  logic                     first_burst,
    input  logic                     last_burst,
    input  rd_burst_pkg::outstd_t    inflight,
    input  rd_burst_pkg::outstd_t    limit,
    input  logic                     request_done
);

    // failed assertions, read by the testbench
    int fail_cnt = 0;

    // ====================
    // address channel
    // ====================

    // waiting burst keeps its fields
    a_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        burst_valid && !burst_ok |=> burst_valid && $stable(burst_addr)
            && $stable(burst_len) && $stable(first_burst) && $stable(last_burst))
        else begin
            fail_cnt++;
            $error("burst fields changed while waiting for ok");
        end

    // no burst in the first two cycles out of reset
    a_reset_valid: assert property (@(posedge aclk)
        $rose(aresetn) |-> !burst_valid ##1 !burst_valid)
        else begin
            fail_cnt++;
            $error("burst_valid high right after reset");
        end

    // ====================
    // credit window and done
    // ====================
    a_window: assert property (@(posedge aclk) disable iff (!aresetn) inflight <= limit)
        else begin
            fail_cnt++;
            $error("in-flight count above the credit limit");
        end

    a_done_pulse: assert property (@(posedge aclk) disable iff (!aresetn)
        request_done |=> !request_done)
        else begin
            fail_cnt++;
            $error("request_done longer than one cycle");
        end

endmodule

// tracker internals reached from the top scope
bind rd_burst_top rd_burst_chk i_chk (
    .aclk         (aclk),
    .aresetn      (aresetn),
    .burst_valid  (burst_valid),
    .burst_ok     (burst_ok),
    .burst_addr   (burst_addr),
    .burst_len    (burst_len),
    .first_burst  (first_burst),
    .last_burst   (last_burst),
    .inflight     (u_tracker.inflight_cnt),
    .limit        (u_tracker.limit),
    .request_done (request_done)
);

//--- tb/tb_rd_burst.sv
`timescale 1ns/10ps
`include "rd_burst_config.svh"

module tb_rd_burst;

    localparam int REQ_PER_PHASE = 8;
    localparam int NUM_REQ       = 4 * REQ_PER_PHASE;
    localparam int OK_HOLD_MAX   = 6;
    localparam int RET_DLY_MAX   = 8;
    // longest request, 600 words at offset 28
    localparam int MAX_BURSTS    = 5;
    localparam int SLAVE_DLY_MAX = OK_HOLD_MAX + RET_DLY_MAX + 4;
    localparam int TIMEOUT_CYC   = NUM_REQ * (MAX_BURSTS * SLAVE_DLY_MAX + 20) + 16;

    logic                     aclk = 1'b0;
    logic                     aresetn;
    rd_burst_pkg::addr_t      fifo_addr;
    rd_burst_pkg::word_cnt_t  fifo_len;
    logic                     fifo_empty;
    logic                     fifo_pop;
    rd_burst_pkg::outstd_t    cfg_outstd;
    logic                     cfg_outstd_en;
    rd_burst_pkg::addr_t      burst_addr;
    rd_burst_pkg::burst_len_t burst_len;
    logic                     burst_valid;
    logic                     first_burst;
    logic                     last_burst;
    logic                     burst_ok;
    logic                     rdata_ok;
    rd_burst_pkg::offset_t    first_offset;
    rd_burst_pkg::offset_t    last_offset;
    logic                     request_done;

    // request fifo model and expected results
    rd_burst_pkg::addr_t      req_addr_q[$];
    rd_burst_pkg::word_cnt_t  req_len_q[$];
    rd_burst_pkg::addr_t      exp_addr[$];
    rd_burst_pkg::burst_len_t exp_len[$];
    logic                     exp_first[$];
    logic                     exp_last[$];
    rd_burst_pkg::offset_t    exp_foff[$];
    rd_burst_pkg::offset_t    exp_loff[$];
    int                       exp_nb[$];
    // slave return delays, oldest first
    int                       ret_q[$];

    int   ok_hold = 0;
    int   unanswered = 0;
    int   bursts_left = 0;
    int   pop_cnt = 0;
    int   done_cnt = 0;
    int   req_total = 0;
    int   errors = 0;
    int   cycle_cnt = 0;
    logic pop_seen = 1'b0;
    logic acc_seen = 1'b0;

    rd_burst_pkg::addr_t     fixed_addr[5] = '{32'h1000, 32'h2004, 32'h3003, 32'h401c, 32'h5000};
    rd_burst_pkg::word_cnt_t fixed_len[5]  = '{128, 128, 1, 600, 256};
    rd_burst_pkg::outstd_t   phase_outstd[4] = '{1, 3, 15, 9};

    rd_burst_top i_dut (.*);

    always #2 aclk = ~aclk;

    // ====================
    // reference model
    // ====================
    function automatic void plan_request(rd_burst_pkg::addr_t addr,
                                         rd_burst_pkg::word_cnt_t len);
        longint aligned;
        longint beats;
        longint bursts;
        longint rem;
        aligned = addr - (addr % 4);
        // 32-byte blocks touched by the request bytes
        beats  = (aligned + 4 * len - 1) / `RD_BEAT_BYTES - aligned / `RD_BEAT_BYTES + 1;
        bursts = (beats + `RD_BURST_MAX - 1) / `RD_BURST_MAX;
        rem    = beats % `RD_BURST_MAX;
        for (longint k = 0; k < bursts; k++) begin
            exp_addr.push_back(rd_burst_pkg::addr_t'(aligned - aligned % `RD_BEAT_BYTES
                + k * `RD_BEAT_BYTES * `RD_BURST_MAX));
            if (k == bursts - 1 && rem != 0) begin
                exp_len.push_back(rd_burst_pkg::burst_len_t'(rem - 1));
            end else begin
                exp_len.push_back(rd_burst_pkg::burst_len_t'(`RD_BURST_MAX - 1));
            end
            exp_first.push_back(k == 0);
            exp_last.push_back(k == bursts - 1);
        end
        exp_nb.push_back(int'(bursts));
        exp_foff.push_back(rd_burst_pkg::offset_t'(aligned % `RD_BEAT_BYTES));
        exp_loff.push_back(rd_burst_pkg::offset_t'((aligned + 4 * len) % `RD_BEAT_BYTES));
    endfunction

    function automatic int window_size();
        return cfg_outstd_en ? int'(cfg_outstd) : 1;
    endfunction

    task automatic addr_compare(string name, rd_burst_pkg::addr_t got, rd_burst_pkg::addr_t exp);
        if (got !== exp) begin
            $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic len_compare(string name, rd_burst_pkg::burst_len_t got,
                               rd_burst_pkg::burst_len_t exp);
        if (got !== exp) begin
            $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic offset_compare(string name, rd_burst_pkg::offset_t got,
                                  rd_burst_pkg::offset_t exp);
        if (got !== exp) begin
            $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic flag_compare(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("error at %0t: %s is %b, expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    // ====================
    // fifo and slave models
    // ====================
    always @(negedge aclk) begin
        // head leaves after the pop edge
        if (pop_seen) begin
            req_addr_q.delete(0);
            req_len_q.delete(0);
        end
        fifo_empty = (req_addr_q.size() == 0);
        if (!fifo_empty) begin
            fifo_addr = req_addr_q[0];
            fifo_len  = req_len_q[0];
        end
        // random spans of back-pressure
        if (ok_hold > 0) begin
            burst_ok = 1'b0;
            ok_hold--;
        end else begin
            burst_ok = 1'b1;
            if ($urandom % 4 == 0) begin
                ok_hold = 1 + $urandom % OK_HOLD_MAX;
            end
        end
        // data returns in issue order
        if (acc_seen) begin
            ret_q.push_back($urandom % RET_DLY_MAX);
        end
        rdata_ok = 1'b0;
        if (ret_q.size() > 0) begin
            if (ret_q[0] == 0) begin
                rdata_ok = 1'b1;
                ret_q.delete(0);
            end else begin
                ret_q[0] = ret_q[0] - 1;
            end
        end
    end

    // ====================
    // compare process
    // ====================
    always @(posedge aclk) begin
        pop_seen <= fifo_pop;
        acc_seen <= burst_valid && burst_ok;
        if (aresetn) begin
            if (burst_valid && burst_ok) begin
                if (exp_addr.size() == 0) begin
                    $display("burst accepted with no burst expected at %0t", $time);
                    errors++;
                end else begin
                    addr_compare("burst_addr", burst_addr, exp_addr.pop_front());
                    len_compare("burst_len", burst_len, exp_len.pop_front());
                    flag_compare("first_burst", first_burst, exp_first.pop_front());
                    flag_compare("last_burst", last_burst, exp_last.pop_front());
                    bursts_left--;
                end
            end
            // bursts accepted and not yet answered
            unanswered = unanswered + int'(burst_valid && burst_ok) - int'(rdata_ok);
            if (unanswered > window_size()) begin
                $display("%0d bursts in flight at %0t, window is %0d", unanswered, $time,
                    window_size());
                errors++;
            end
            if (fifo_pop) begin
                if (done_cnt != pop_cnt) begin
                    $display("fifo_pop before the previous request finished at %0t", $time);
                    errors++;
                end
                pop_cnt++;
                bursts_left = exp_nb.pop_front();
            end
            if (pop_seen) begin
                offset_compare("first_offset", first_offset, exp_foff.pop_front());
                offset_compare("last_offset", last_offset, exp_loff.pop_front());
            end
            if (request_done) begin
                if (done_cnt != pop_cnt - 1 || bursts_left != 0 || unanswered != 0) begin
                    $display("request_done before the request was complete at %0t", $time);
                    errors++;
                end
                done_cnt++;
            end
        end
    end

    always @(posedge aclk) begin
        cycle_cnt++;
        if (cycle_cnt > TIMEOUT_CYC) begin
            $display("timeout after %0d cycles, %0d of %0d requests done", cycle_cnt,
                done_cnt, req_total);
            $display("%0d errors, %0d assertion failures", errors, i_dut.i_chk.fail_cnt);
            $display("TEST FAIL");
            $finish;
        end
    end

    // ====================
    // stimulus
    // ====================
    initial begin
        rd_burst_pkg::addr_t     a;
        rd_burst_pkg::word_cnt_t n;
        void'($urandom(32'h2a80));
        aresetn       = 1'b0;
        fifo_addr     = '0;
        fifo_len      = '0;
        fifo_empty    = 1'b1;
        burst_ok      = 1'b0;
        rdata_ok      = 1'b0;
        cfg_outstd    = 4'd1;
        cfg_outstd_en = 1'b1;
        repeat (16) @(negedge aclk);
        aresetn = 1'b1;
        // window 1, 3 and 15, then outstanding off
        for (int p = 0; p < 4; p++) begin
            @(negedge aclk);
            cfg_outstd    = phase_outstd[p];
            cfg_outstd_en = (p != 3);
            @(posedge aclk);
            for (int r = 0; r < REQ_PER_PHASE; r++) begin
                if (r < 5) begin
                    a = fixed_addr[r];
                    n = fixed_len[r];
                end else begin
                    a = $urandom & 32'h00ff_ffff;
                    n = 1 + $urandom % 600;
                end
                req_addr_q.push_back(a);
                req_len_q.push_back(n);
                plan_request(a, n);
            end
            req_total += REQ_PER_PHASE;
            while (done_cnt != req_total) begin
                @(negedge aclk);
            end
        end
        repeat (4) @(negedge aclk);
        if (exp_addr.size() != 0) begin
            $display("%0d expected bursts were never issued", exp_addr.size());
            errors++;
        end
        $display("%0d errors, %0d assertion failures", errors, i_dut.i_chk.fail_cnt);
        if (errors == 0 && i_dut.i_chk.fail_cnt == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
